//--- rtl/byte_ingress.sv
`timescale 1ns/10ps
`default_nettype none

module byte_ingress
   import fifo_pkg::*;
   #(
   parameter int W_DATA_W = W_DATA_W_DEF
   ) (
   input  wire                 clk_i,
   input  wire                 rst_n_i,
   input  wire                 in_valid_i,
   input  wire  [W_DATA_W-1:0] in_data_i,
   input  wire                 fifo_full_i,
   output logic                fifo_w_en_o,
   output logic [W_DATA_W-1:0] fifo_w_data_o,
   output cnt_t                drop_cnt_o
   );

   logic drop;

   // no stall, a byte offered while full is lost
   assign fifo_w_en_o   = in_valid_i & ~fifo_full_i;
   assign fifo_w_data_o = in_data_i;
   assign drop          = in_valid_i & fifo_full_i;

   always_ff @(posedge clk_i) begin
      if (!rst_n_i) begin
         drop_cnt_o <= '0;
      end else if (drop && (drop_cnt_o != '1)) begin
         // saturates at all ones
         drop_cnt_o <= drop_cnt_o + cnt_t'(1);
      end
   end

endmodule

`default_nettype wire

//--- rtl/ext_mem_if.sv
`timescale 1ns/10ps
`default_nettype none

interface ext_mem_if
   import fifo_pkg::*;
   #(
   parameter int N   = N_LANES_DEF,
   parameter int A_W = ADDR_W_DEF,
   parameter int D_W = W_DATA_W_DEF
   ) ();

   // one field per lane, addresses are byte granular
   logic [N-1:0]     w_en;
   logic [N*D_W-1:0] w_data;
   logic [N*A_W-1:0] w_addr;
   logic             r_en;
   logic [N*A_W-1:0] r_addr;
   logic [N*D_W-1:0] r_data;

   modport fifo (
      output w_en, w_data, w_addr, r_en, r_addr,
      input  r_data
   );

   modport mem (
      input  w_en, w_data, w_addr, r_en, r_addr,
      output r_data
   );

endinterface

`default_nettype wire

//--- rtl/fifo_asym_top.sv
`timescale 1ns/10ps
`default_nettype none

module fifo_asym_top
   import fifo_pkg::*;
   #(
   parameter int W_DATA_W = W_DATA_W_DEF,
   parameter int R_DATA_W = R_DATA_W_DEF,
   parameter int ADDR_W   = ADDR_W_DEF
   ) (
   input  wire                 clk_i,
   input  wire                 rst_n_i,
   input  wire                 in_valid_i,
   input  wire  [W_DATA_W-1:0] in_data_i,
   input  wire                 out_rd_i,
   output logic                out_valid_o,
   output logic [R_DATA_W-1:0] out_data_o,
   output logic                full_o,
   output logic                empty_o,
   output logic [ADDR_W:0]     level_o,
   output cnt_t                drop_cnt_o,
   output cnt_t                underflow_cnt_o
   );

   localparam int N       = R_DATA_W / W_DATA_W;
   localparam int BANK_AW = ADDR_W - $clog2(N);

   logic                  fifo_w_en;
   logic [W_DATA_W-1:0]   fifo_w_data;
   logic                  fifo_r_en;
   logic [R_DATA_W-1:0]   fifo_r_data;

   logic [N-1:0]          bank_w_en;
   logic [N*BANK_AW-1:0]  bank_w_addr;
   logic [N*W_DATA_W-1:0] bank_w_data;
   logic                  bank_r_en;
   logic [N*BANK_AW-1:0]  bank_r_addr;
   logic [N*W_DATA_W-1:0] bank_r_data;

   ext_mem_if #(
      .N   (N),
      .A_W (ADDR_W),
      .D_W (W_DATA_W)
   ) mem_if ();

   byte_ingress #(
      .W_DATA_W (W_DATA_W)
   ) byte_ingress_inst (
      .clk_i         (clk_i),
      .rst_n_i       (rst_n_i),
      .in_valid_i    (in_valid_i),
      .in_data_i     (in_data_i),
      .fifo_full_i   (full_o),
      .fifo_w_en_o   (fifo_w_en),
      .fifo_w_data_o (fifo_w_data),
      .drop_cnt_o    (drop_cnt_o)
   );

   fifo_sync_asym #(
      .W_DATA_W (W_DATA_W),
      .R_DATA_W (R_DATA_W),
      .ADDR_W   (ADDR_W)
   ) fifo_sync_asym_inst (
      .clk_i     (clk_i),
      .rst_n_i   (rst_n_i),
      .w_en_i    (fifo_w_en),
      .w_data_i  (fifo_w_data),
      .w_full_o  (full_o),
      .r_en_i    (fifo_r_en),
      .r_data_o  (fifo_r_data),
      .r_empty_o (empty_o),
      .level_o   (level_o),
      .mem       (mem_if.fifo)
   );

   ram_2p_asym #(
      .W_DATA_W (W_DATA_W),
      .R_DATA_W (R_DATA_W),
      .ADDR_W   (ADDR_W)
   ) ram_2p_asym_inst (
      .clk_i         (clk_i),
      .mem           (mem_if.mem),
      .bank_w_en_o   (bank_w_en),
      .bank_w_addr_o (bank_w_addr),
      .bank_w_data_o (bank_w_data),
      .bank_r_en_o   (bank_r_en),
      .bank_r_addr_o (bank_r_addr),
      .bank_r_data_i (bank_r_data)
   );

   // one byte bank per lane
   for (genvar k = 0; k < N; k++) begin : g_bank
      mem_bank_2p #(
         .DATA_W (W_DATA_W),
         .ADDR_W (BANK_AW)
      ) mem_bank_2p_inst (
         .clk_i    (clk_i),
         .w_en_i   (bank_w_en[k]),
         .w_addr_i (bank_w_addr[k*BANK_AW +: BANK_AW]),
         .w_data_i (bank_w_data[k*W_DATA_W +: W_DATA_W]),
         .r_en_i   (bank_r_en),
         .r_addr_i (bank_r_addr[k*BANK_AW +: BANK_AW]),
         .r_data_o (bank_r_data[k*W_DATA_W +: W_DATA_W])
      );
   end

   word_egress #(
      .R_DATA_W (R_DATA_W)
   ) word_egress_inst (
      .clk_i           (clk_i),
      .rst_n_i         (rst_n_i),
      .out_rd_i        (out_rd_i),
      .fifo_empty_i    (empty_o),
      .fifo_r_en_o     (fifo_r_en),
      .fifo_r_data_i   (fifo_r_data),
      .out_valid_o     (out_valid_o),
      .out_data_o      (out_data_o),
      .underflow_cnt_o (underflow_cnt_o)
   );

endmodule

`default_nettype wire

//--- rtl/fifo_pkg.sv
`default_nettype none

package fifo_pkg;

   // default datapath shape
   localparam int W_DATA_W_DEF = 8;
   localparam int R_DATA_W_DEF = 32;
   localparam int ADDR_W_DEF   = 6;

   // byte lanes per word and the depth of one bank
   localparam int N_LANES_DEF     = R_DATA_W_DEF / W_DATA_W_DEF;
   localparam int LANE_SEL_W_DEF  = $clog2(N_LANES_DEF);
   localparam int BANK_ADDR_W_DEF = ADDR_W_DEF - LANE_SEL_W_DEF;

   // event counters
   localparam int CNT_W = 16;

   typedef logic [CNT_W-1:0] cnt_t;

endpackage

`default_nettype wire

//--- rtl/fifo_sync_asym.sv
`timescale 1ns/10ps
`default_nettype none

module fifo_sync_asym
   import fifo_pkg::*;
   #(
   parameter int W_DATA_W = W_DATA_W_DEF,
   parameter int R_DATA_W = R_DATA_W_DEF,
   parameter int ADDR_W   = ADDR_W_DEF
   ) (
   input  wire                 clk_i,
   input  wire                 rst_n_i,
   input  wire                 w_en_i,
   input  wire  [W_DATA_W-1:0] w_data_i,
   output logic                w_full_o,
   input  wire                 r_en_i,
   output logic [R_DATA_W-1:0] r_data_o,
   output logic                r_empty_o,
   output logic [ADDR_W:0]     level_o,
   ext_mem_if.fifo             mem
   );

   localparam int N       = R_DATA_W / W_DATA_W;
   localparam int LANE_W  = $clog2(N);
   localparam int WORD_AW = ADDR_W - LANE_W;

   // level is kept in bytes
   localparam logic [ADDR_W:0] FIFO_SIZE = (ADDR_W+1)'(1) << ADDR_W;
   localparam logic [ADDR_W:0] W_INCR    = (ADDR_W+1)'(1);
   localparam logic [ADDR_W:0] R_INCR    = (ADDR_W+1)'(N);

   logic               w_en_int;
   logic               r_en_int;
   logic [ADDR_W-1:0]  w_addr_q;
   logic [WORD_AW-1:0] r_addr_q;
   logic [ADDR_W-1:0]  r_byte_addr;
   logic [ADDR_W:0]    level_nxt;

   assign w_en_int = w_en_i & ~w_full_o;
   assign r_en_int = r_en_i & ~r_empty_o;

   // byte write pointer, word read pointer
   always_ff @(posedge clk_i) begin
      if (!rst_n_i) begin
         w_addr_q <= '0;
         r_addr_q <= '0;
      end else begin
         if (w_en_int) begin
            w_addr_q <= w_addr_q + 1'b1;
         end
         if (r_en_int) begin
            r_addr_q <= r_addr_q + 1'b1;
         end
      end
   end

   always_comb begin
      level_nxt = level_o;
      if (w_en_int) begin
         level_nxt = level_nxt + W_INCR;
      end
      if (r_en_int) begin
         level_nxt = level_nxt - R_INCR;
      end
   end

   // flags come from the next level so they line up with level_o
   always_ff @(posedge clk_i) begin
      if (!rst_n_i) begin
         level_o   <= '0;
         r_empty_o <= 1'b1;
         w_full_o  <= 1'b0;
      end else begin
         level_o   <= level_nxt;
         r_empty_o <= (level_nxt < R_INCR);
         w_full_o  <= (level_nxt > (FIFO_SIZE - W_INCR));
      end
   end

   assign r_byte_addr = ADDR_W'(r_addr_q) << LANE_W;

   // every lane sees the byte and its address, the mapper picks the bank
   assign mem.w_en   = {N{w_en_int}};
   assign mem.w_data = {N{w_data_i}};
   assign mem.w_addr = {N{w_addr_q}};
   assign mem.r_en   = r_en_int;
   assign mem.r_addr = {N{r_byte_addr}};

   assign r_data_o = mem.r_data;

endmodule

`default_nettype wire

//--- rtl/mem_bank_2p.sv
`timescale 1ns/10ps
`default_nettype none

module mem_bank_2p
   import fifo_pkg::*;
   #(
   parameter int DATA_W = W_DATA_W_DEF,
   parameter int ADDR_W = BANK_ADDR_W_DEF
   ) (
   input  wire               clk_i,
   input  wire               w_en_i,
   input  wire  [ADDR_W-1:0] w_addr_i,
   input  wire  [DATA_W-1:0] w_data_i,
   input  wire               r_en_i,
   input  wire  [ADDR_W-1:0] r_addr_i,
   output logic [DATA_W-1:0] r_data_o
   );

   logic [DATA_W-1:0] mem_q [2**ADDR_W];

   always_ff @(posedge clk_i) begin
      if (w_en_i) begin
         mem_q[w_addr_i] <= w_data_i;
      end
   end

   // output holds between reads
   always_ff @(posedge clk_i) begin
      if (r_en_i) begin
         r_data_o <= mem_q[r_addr_i];
      end
   end

endmodule

`default_nettype wire

//--- rtl/ram_2p_asym.sv
`timescale 1ns/10ps
`default_nettype none

module ram_2p_asym
   import fifo_pkg::*;
   #(
   parameter  int W_DATA_W = W_DATA_W_DEF,
   parameter  int R_DATA_W = R_DATA_W_DEF,
   parameter  int ADDR_W   = ADDR_W_DEF,
   localparam int N        = R_DATA_W / W_DATA_W,
   localparam int LANE_W   = $clog2(N),
   localparam int BANK_AW  = ADDR_W - LANE_W
   ) (
   input  wire                   clk_i,
   ext_mem_if.mem                mem,
   output logic [N-1:0]          bank_w_en_o,
   output logic [N*BANK_AW-1:0]  bank_w_addr_o,
   output logic [N*W_DATA_W-1:0] bank_w_data_o,
   output logic                  bank_r_en_o,
   output logic [N*BANK_AW-1:0]  bank_r_addr_o,
   input  wire  [N*W_DATA_W-1:0] bank_r_data_i
   );

   localparam logic [ADDR_W-1:0] LANE_MASK = ADDR_W'(N - 1);

   logic [R_DATA_W-1:0] rd_word;
   logic                rd_vld_q;

   for (genvar k = 0; k < N; k++) begin : g_lane
      logic [ADDR_W-1:0] w_byte_addr;
      logic [ADDR_W-1:0] r_byte_addr;
      logic [ADDR_W-1:0] w_row;
      logic [ADDR_W-1:0] r_row;

      assign w_byte_addr = mem.w_addr[k*ADDR_W +: ADDR_W];
      assign r_byte_addr = mem.r_addr[k*ADDR_W +: ADDR_W];

      // low bits select the bank, upper bits the row inside it
      assign w_row = w_byte_addr >> LANE_W;
      assign r_row = r_byte_addr >> LANE_W;

      assign bank_w_en_o[k] = mem.w_en[k] & ((w_byte_addr & LANE_MASK) == ADDR_W'(k));
      assign bank_w_addr_o[k*BANK_AW +: BANK_AW]   = w_row[BANK_AW-1:0];
      assign bank_w_data_o[k*W_DATA_W +: W_DATA_W] = mem.w_data[k*W_DATA_W +: W_DATA_W];
      assign bank_r_addr_o[k*BANK_AW +: BANK_AW]   = r_row[BANK_AW-1:0];

      // bank 0 ends up in the low byte
      assign rd_word[k*W_DATA_W +: W_DATA_W] = bank_r_data_i[k*W_DATA_W +: W_DATA_W];
   end

   // whole word read, all banks at once
   assign bank_r_en_o = mem.r_en;

   always_ff @(posedge clk_i) begin
      rd_vld_q <= mem.r_en;
   end

   // zero between reads, stale bank data stays off the port
   assign mem.r_data = rd_vld_q ? rd_word : '0;

endmodule

`default_nettype wire

//--- rtl/word_egress.sv
`timescale 1ns/10ps
`default_nettype none

module word_egress
   import fifo_pkg::*;
   #(
   parameter int R_DATA_W = R_DATA_W_DEF
   ) (
   input  wire                 clk_i,
   input  wire                 rst_n_i,
   input  wire                 out_rd_i,
   input  wire                 fifo_empty_i,
   output logic                fifo_r_en_o,
   input  wire  [R_DATA_W-1:0] fifo_r_data_i,
   output logic                out_valid_o,
   output logic [R_DATA_W-1:0] out_data_o,
   output cnt_t                underflow_cnt_o
   );

   logic rd_ok;
   logic rd_miss;

   assign rd_ok   = out_rd_i & ~fifo_empty_i;
   assign rd_miss = out_rd_i & fifo_empty_i;

   assign fifo_r_en_o = rd_ok;

   // bank output is valid one cycle after the accepted read
   always_ff @(posedge clk_i) begin
      if (!rst_n_i) begin
         out_valid_o <= 1'b0;
      end else begin
         out_valid_o <= rd_ok;
      end
   end

   always_ff @(posedge clk_i) begin
      if (!rst_n_i) begin
         underflow_cnt_o <= '0;
      end else if (rd_miss && (underflow_cnt_o != '1)) begin
         underflow_cnt_o <= underflow_cnt_o + cnt_t'(1);
      end
   end

   assign out_data_o = fifo_r_data_i;

endmodule

`default_nettype wire

//--- tb.f
rtl/fifo_pkg.sv
rtl/ext_mem_if.sv
rtl/byte_ingress.sv
rtl/fifo_sync_asym.sv
rtl/ram_2p_asym.sv
rtl/mem_bank_2p.sv
rtl/word_egress.sv
rtl/fifo_asym_top.sv
tb/tb_fifo_asym_top.sv

//--- tb/fifo_input.txt
# test name, command, value (hex for W and R, decimal for all others)
# W byte, R word, L level, D drops, U underflows, F full, E empty, V valid
# I idle cycles, P random fill, Q word requests, S mixed random stream
reset  E 1
reset  F 0
reset  L 0
reset  D 0
reset  U 0
reset  V 0
pack   W 11
pack   W 22
pack   W 33
pack   I 2
pack   L 3
pack   E 1
pack   W 44
pack   E 0
pack   L 4
pack   R 44332211
pack   I 1
pack   L 0
pack   E 1
under  Q 3
under  U 3
over   P 70
over   F 1
over   L 64
over   D 6
over   Q 16
over   E 1
over   L 0
mixed  S 60
mixed  D 6
mixed  U 3

//--- tb/tb_fifo_asym_top.sv
`timescale 1ns/10ps
`default_nettype none

module tb_fifo_asym_top
   import fifo_pkg::*;
   ();

   localparam int CLK_PERIOD   = 40;
   localparam int RESET_CYCLES = 8;
   localparam int LANES        = R_DATA_W_DEF / W_DATA_W_DEF;
   localparam int FIFO_BYTES   = 1 << ADDR_W_DEF;

   logic                    clk_i;
   logic                    rst_n_i;
   logic                    in_valid_i;
   logic [W_DATA_W_DEF-1:0] in_data_i;
   logic                    out_rd_i;
   logic                    out_valid_o;
   logic [R_DATA_W_DEF-1:0] out_data_o;
   logic                    full_o;
   logic                    empty_o;
   logic [ADDR_W_DEF:0]     level_o;
   cnt_t                    drop_cnt_o;
   cnt_t                    underflow_cnt_o;

   // script entries and the byte model
   string      t_name[$];
   logic [7:0] t_cmd[$];
   int         t_val[$];
   logic [7:0] byte_q[$];
   int         model_level;
   int         errors;
   int         checks;
   int         budget;
   bit         script_loaded;
   string      cur_name;
   integer     seed = 53784;
   logic [7:0] rnd_byte;
   logic       rnd_rd;

   fifo_asym_top #(
      .W_DATA_W (W_DATA_W_DEF),
      .R_DATA_W (R_DATA_W_DEF),
      .ADDR_W   (ADDR_W_DEF)
   ) fifo_asym_top_inst (
      .clk_i           (clk_i),
      .rst_n_i         (rst_n_i),
      .in_valid_i      (in_valid_i),
      .in_data_i       (in_data_i),
      .out_rd_i        (out_rd_i),
      .out_valid_o     (out_valid_o),
      .out_data_o      (out_data_o),
      .full_o          (full_o),
      .empty_o         (empty_o),
      .level_o         (level_o),
      .drop_cnt_o      (drop_cnt_o),
      .underflow_cnt_o (underflow_cnt_o)
   );

   initial clk_i = 1'b0;
   always #(CLK_PERIOD / 2) clk_i = ~clk_i;

   task automatic check_val(input string what, input logic [31:0] exp, input logic [31:0] act);
      checks++;
      assert (exp === act)
      else begin
         errors++;
         $display("Fail %s %s expected %0h actual %0h", cur_name, what, exp, act);
      end
   endtask

   task automatic load_script();
      int    fd;
      int    r;
      int    v;
      string name;
      string cmd;
      string val_s;
      string rest;
      fd = $fopen("tb/fifo_input.txt", "r");
      if (fd == 0) begin
         errors++;
         $display("could not open the data file tb/fifo_input.txt");
      end else begin
         while ($fscanf(fd, "%s", name) == 1) begin
            if (name[0] == "#") begin
               r = $fgets(rest, fd);
            end else begin
               r = $fscanf(fd, "%s %s", cmd, val_s);
               // bytes and words in hex, counts and levels in decimal
               if (cmd == "W" || cmd == "R") begin
                  r = $sscanf(val_s, "%h", v);
               end else begin
                  r = $sscanf(val_s, "%d", v);
               end
               t_name.push_back(name);
               t_cmd.push_back(cmd[0]);
               t_val.push_back(v);
               budget += 1;
               if (cmd == "I" || cmd == "P" || cmd == "Q" || cmd == "S") begin
                  budget += v;
               end
            end
         end
         $fclose(fd);
      end
   endtask

   // drive one clock of stimulus and check the response just after the edge
   task automatic run_cycle(input logic wr, input logic [7:0] wd, input logic rd,
                            input logic use_file, input logic [31:0] file_word);
      logic        acc_w;
      logic        acc_r;
      logic [31:0] exp_word;
      acc_w    = wr && (model_level < FIFO_BYTES);
      acc_r    = rd && (model_level >= LANES);
      exp_word = '0;
      if (acc_r) begin
         // first byte in is the low byte
         for (int i = 0; i < LANES; i++) begin
            exp_word[8*i +: 8] = byte_q.pop_front();
         end
         if (use_file) begin
            exp_word = file_word;
         end
      end
      if (acc_w) begin
         byte_q.push_back(wd);
      end
      in_valid_i = wr;
      in_data_i  = wd;
      out_rd_i   = rd;
      @(posedge clk_i);
      #2;
      in_valid_i  = 1'b0;
      out_rd_i    = 1'b0;
      model_level = model_level + (acc_w ? 1 : 0) - (acc_r ? LANES : 0);
      check_val("out_valid", acc_r, out_valid_o);
      // empty below one word, full at the byte capacity
      check_val("empty flag", model_level < LANES, empty_o);
      check_val("full flag", model_level >= FIFO_BYTES, full_o);
      if (acc_r) begin
         check_val("word", exp_word, out_data_o);
      end
   endtask

   initial begin
      wait (script_loaded);
      #(budget * CLK_PERIOD);
      $display("watchdog expired before the data file was replayed");
      $display("** FAIL **");
      $finish;
   end

   initial begin
      rst_n_i     = 1'b0;
      in_valid_i  = 1'b0;
      in_data_i   = '0;
      out_rd_i    = 1'b0;
      errors      = 0;
      checks      = 0;
      model_level = 0;
      budget      = RESET_CYCLES + 200;
      cur_name    = "load";
      load_script();
      script_loaded = 1'b1;
      repeat (RESET_CYCLES) @(posedge clk_i);
      #2;
      rst_n_i = 1'b1;
      foreach (t_cmd[i]) begin
         cur_name = t_name[i];
         case (t_cmd[i])
            "W": run_cycle(1'b1, 8'(t_val[i]), 1'b0, 1'b0, '0);
            "R": run_cycle(1'b0, '0, 1'b1, 1'b1, t_val[i]);
            "L": check_val("level", t_val[i], level_o);
            "D": check_val("drop count", t_val[i], drop_cnt_o);
            "U": check_val("underflow count", t_val[i], underflow_cnt_o);
            "F": check_val("full", t_val[i], full_o);
            "E": check_val("empty", t_val[i], empty_o);
            "V": check_val("out_valid", t_val[i], out_valid_o);
            "I": repeat (t_val[i]) run_cycle(1'b0, '0, 1'b0, 1'b0, '0);
            "Q": repeat (t_val[i]) run_cycle(1'b0, '0, 1'b1, 1'b0, '0);
            "P": begin
               repeat (t_val[i]) begin
                  rnd_byte = $random(seed);
                  run_cycle(1'b1, rnd_byte, 1'b0, 1'b0, '0);
               end
            end
            "S": begin
               // reads only where the FIFO holds a word
               repeat (t_val[i]) begin
                  rnd_byte = $random(seed);
                  rnd_rd   = $random(seed);
                  run_cycle(1'b1, rnd_byte, rnd_rd && (model_level >= LANES), 1'b0, '0);
               end
               check_val("final level", model_level, level_o);
            end
            default: begin
               errors++;
               $display("unknown command in data file at test %s", cur_name);
            end
         endcase
      end
      $display("checks %0d errors %0d", checks, errors);
      if (errors == 0) begin
         $display("** PASS **");
      end else begin
         $display("** FAIL **");
      end
      $finish;
   end

endmodule

`default_nettype wire
